//--- verilog/sysctrl_pkg.sv
// shared types, command codes, config ids and constants for the mcu system control block
package sysctrl_pkg;

  // one spi byte, also used for command codes, ids and values
  typedef logic [7:0] byte_t;

  // rgb value for the addressable led
  typedef logic [23:0] color_t;

  // command byte that opens every spi frame
  typedef enum logic [7:0] {
    CMD_STATUS  = 8'd0,
    CMD_LEDS    = 8'd1,
    CMD_COLOR   = 8'd2,
    CMD_BUTTONS = 8'd3,
    CMD_CONFIG  = 8'd4,
    CMD_IRQ     = 8'd5,
    CMD_IRQ_SRC = 8'd6
  } cmd_e;

  // status reply, a pattern an unprogrammed device would not give
  localparam byte_t STATUS_MAGIC0 = 8'h5c;
  localparam byte_t STATUS_MAGIC1 = 8'h42;
  // core id 2 is the c64
  localparam byte_t CORE_ID       = 8'h02;

  // about three seconds at the core clock
  localparam int unsigned BOOT_HOLD_CYCLES = 80_000_000;

  // dim color shown when no mcu has answered before the hold ran out
  localparam color_t NO_MCU_COLOR = 24'h000202;

  // config ids, sent as ascii characters
  localparam byte_t ID_REU         = "V";
  localparam byte_t ID_RESET       = "R";
  localparam byte_t ID_SCANLINES   = "S";
  localparam byte_t ID_VOLUME      = "A";
  localparam byte_t ID_WIDE        = "W";
  localparam byte_t ID_WPROT       = "P";
  localparam byte_t ID_PORT1       = "Q";
  localparam byte_t ID_PORT2       = "J";
  localparam byte_t ID_DOS         = "D";
  localparam byte_t ID_DRIVE_RESET = "Z";
  localparam byte_t ID_TURBO_MODE  = "X";
  localparam byte_t ID_TURBO_SPEED = "Y";
  localparam byte_t ID_PAUSE       = "G";
  localparam byte_t ID_DETACH      = "F";

  // non-zero defaults, volume 66% and port 1 off
  localparam logic [1:0] DEF_VOLUME = 2'd2;
  localparam logic [3:0] DEF_PORT1  = 4'd7;

endpackage

//--- verilog/mcu_spi_target.sv
// spi mode 0 target toward the board mcu, turns the link into byte strobes and replies
`timescale 1ns/1ps

module mcu_spi_target (
  input  logic                clk,
  input  logic                main_reset_timeout,
  input  logic                spi_csn_i,
  input  logic                spi_sck_i,
  input  logic                spi_mosi_i,
  input  sysctrl_pkg::byte_t  tx_byte_i,
  output logic                spi_miso_o,
  output logic                rx_strobe_o,
  output logic                rx_start_o,
  output sysctrl_pkg::byte_t  rx_byte_o
);
  import sysctrl_pkg::*;

  // two flop synchronizers for the pins
  logic [1:0] csn_sync;
  logic [1:0] sck_sync;
  logic [1:0] mosi_sync;
  // previous synchronized sck for edge detect
  logic       sck_d;
  logic [2:0] bit_cnt;
  logic [6:0] rx_shift;
  byte_t      tx_shift;
  // set until the first byte of a frame has been received
  logic       first_byte;

  logic sck_rise;
  logic sck_fall;
  logic csn_act;

  assign sck_rise   = sck_sync[1] & ~sck_d;
  assign sck_fall   = ~sck_sync[1] & sck_d;
  assign csn_act    = ~csn_sync[1];
  // msb first
  assign spi_miso_o = tx_shift[7];

  always_ff @(posedge clk) begin
    if (main_reset_timeout) begin
      csn_sync    <= 2'b11;
      sck_sync    <= 2'b00;
      mosi_sync   <= 2'b00;
      sck_d       <= 1'b0;
      bit_cnt     <= 3'd0;
      tx_shift    <= '0;
      first_byte  <= 1'b1;
      rx_strobe_o <= 1'b0;
      rx_start_o  <= 1'b0;
    end else begin
      csn_sync    <= {csn_sync[0], spi_csn_i};
      sck_sync    <= {sck_sync[0], spi_sck_i};
      mosi_sync   <= {mosi_sync[0], spi_mosi_i};
      sck_d       <= sck_sync[1];
      rx_strobe_o <= 1'b0;
      if (!csn_act) begin
        // idle between frames
        bit_cnt    <= 3'd0;
        tx_shift   <= '0;
        first_byte <= 1'b1;
      end else begin
        if (sck_rise) begin
          bit_cnt <= bit_cnt + 3'd1;
          if (bit_cnt == 3'd7) begin
            rx_strobe_o <= 1'b1;
            rx_start_o  <= first_byte;
            first_byte  <= 1'b0;
          end
        end
        // falling edge after the eighth bit starts the next reply byte
        if (sck_fall) begin
          if (bit_cnt == 3'd0) begin
            tx_shift <= tx_byte_i;
          end else begin
            tx_shift <= {tx_shift[6:0], 1'b0};
          end
        end
      end
    end
  end

  // mosi sampled on sck rising
  always_ff @(posedge clk) begin
    if (csn_act && sck_rise) begin
      rx_shift <= {rx_shift[5:0], mosi_sync[1]};
      if (bit_cnt == 3'd7) begin
        rx_byte_o <= {rx_shift, mosi_sync[1]};
      end
    end
  end

  // the next sck fall loads tx_byte, so sck stays high until sysctrl has answered
  assert property (@(posedge clk) disable iff (main_reset_timeout)
    rx_strobe_o |-> !sck_fall);

endmodule

//--- verilog/sysctrl.sv
// command sequencer, decodes spi frames from the mcu and builds the reply bytes
`timescale 1ns/1ps

module sysctrl (
  input  logic                clk,
  input  logic                main_reset_timeout,
  input  logic                rx_strobe_i,
  input  logic                rx_start_i,
  input  sysctrl_pkg::byte_t  rx_byte_i,
  input  logic [1:0]          buttons_i,
  input  sysctrl_pkg::byte_t  int_in_i,
  input  logic                sys_int_i,
  input  logic                coldboot_i,
  input  logic                hold_expired_i,
  input  sysctrl_pkg::color_t boot_color_i,
  output sysctrl_pkg::byte_t  tx_byte_o,
  output logic [1:0]          leds_o,
  output sysctrl_pkg::color_t color_o,
  output logic                cfg_we_o,
  output sysctrl_pkg::byte_t  cfg_id_o,
  output sysctrl_pkg::byte_t  cfg_val_o,
  output logic                irq_ack_we_o,
  output sysctrl_pkg::byte_t  irq_ack_val_o,
  output logic                src_read_o
);
  import sysctrl_pkg::*;

  cmd_e       cmd;
  // position in the frame, 0 means no frame seen yet
  logic [3:0] byte_idx;
  // id byte of a pending config write
  byte_t      cfg_id_q;
  byte_t      rx_rev;
  // any byte after the command byte
  logic       arg_strobe;

  // color bytes arrive lsb first
  always_comb begin
    for (int i = 0; i < 8; i++) begin
      rx_rev[i] = rx_byte_i[7-i];
    end
  end

  assign arg_strobe = rx_strobe_i && !rx_start_i && (byte_idx != 4'd0);

  // write strobes go out with the byte so the targets update on the next edge
  assign cfg_we_o      = arg_strobe && (cmd == CMD_CONFIG) && (byte_idx == 4'd2);
  assign cfg_id_o      = cfg_id_q;
  assign cfg_val_o     = rx_byte_i;
  assign irq_ack_we_o  = arg_strobe && (cmd == CMD_IRQ) && (byte_idx == 4'd1);
  assign irq_ack_val_o = rx_byte_i;
  // reading the source acknowledges the cold boot
  assign src_read_o    = arg_strobe && (cmd == CMD_IRQ_SRC) && (byte_idx == 4'd1);

  always_ff @(posedge clk) begin
    if (main_reset_timeout) begin
      cmd       <= CMD_STATUS;
      byte_idx  <= 4'd0;
      cfg_id_q  <= '0;
      tx_byte_o <= '0;
      leds_o    <= 2'b00;
      color_o   <= '0;
    end else begin
      // no mcu so far, show the fallback color
      if (hold_expired_i) begin
        color_o <= boot_color_i;
      end
      if (rx_strobe_i && rx_start_i) begin
        byte_idx <= 4'd1;
        cmd      <= cmd_e'(rx_byte_i);
      end else if (arg_strobe) begin
        // long frames park at 15
        if (byte_idx != 4'd15) begin
          byte_idx <= byte_idx + 4'd1;
        end
        case (cmd)
          CMD_STATUS: begin
            case (byte_idx)
              4'd1:    tx_byte_o <= STATUS_MAGIC0;
              4'd2:    tx_byte_o <= STATUS_MAGIC1;
              4'd3:    tx_byte_o <= CORE_ID;
              default: ;
            endcase
          end
          CMD_LEDS: begin
            if (byte_idx == 4'd1) begin
              leds_o <= rx_byte_i[1:0];
            end
          end
          CMD_COLOR: begin
            // wire order is g, b, r
            case (byte_idx)
              4'd1:    color_o[15:8]  <= rx_rev;
              4'd2:    color_o[7:0]   <= rx_rev;
              4'd3:    color_o[23:16] <= rx_rev;
              default: ;
            endcase
          end
          CMD_BUTTONS: tx_byte_o <= {6'b000000, buttons_i};
          CMD_CONFIG: begin
            if (byte_idx == 4'd1) begin
              cfg_id_q <= rx_byte_i;
            end
          end
          // bit 0 stands for the system interrupt
          CMD_IRQ:     tx_byte_o <= {int_in_i[7:1], sys_int_i};
          CMD_IRQ_SRC: tx_byte_o <= {7'b0000000, coldboot_i};
          default: ;
        endcase
      end
    end
  end

  // every frame opens with a flagged first byte, so no argument byte arrives unframed
  assert property (@(posedge clk) disable iff (main_reset_timeout)
    (rx_strobe_i && !rx_start_i) |-> (byte_idx != 4'd0));

endmodule

//--- verilog/cfg_store.sv
// user configuration registers, written by the mcu by id character and value
`timescale 1ns/1ps

module cfg_store (
  input  logic               clk,
  input  logic               main_reset_timeout,
  input  logic               cfg_we_i,
  input  sysctrl_pkg::byte_t cfg_id_i,
  input  sysctrl_pkg::byte_t cfg_val_i,
  output logic               reu_cfg_o,
  output logic [1:0]         scanlines_o,
  output logic [1:0]         volume_o,
  output logic               wide_screen_o,
  output logic [1:0]         floppy_wprot_o,
  output logic [3:0]         port_1_o,
  output logic [3:0]         port_2_o,
  output logic [1:0]         dos_sel_o,
  output logic [1:0]         turbo_mode_o,
  output logic [1:0]         turbo_speed_o,
  output logic               pause_o,
  output logic               detach_reset_o
);
  import sysctrl_pkg::*;

  always_ff @(posedge clk) begin
    if (main_reset_timeout) begin
      // sane defaults, the mcu usually overrides them early
      reu_cfg_o      <= 1'b0;
      scanlines_o    <= 2'd0;
      volume_o       <= DEF_VOLUME;
      wide_screen_o  <= 1'b0;
      floppy_wprot_o <= 2'd0;
      port_1_o       <= DEF_PORT1;
      port_2_o       <= 4'd0;
      dos_sel_o      <= 2'd0;
      turbo_mode_o   <= 2'd0;
      turbo_speed_o  <= 2'd0;
      pause_o        <= 1'b0;
      detach_reset_o <= 1'b0;
    end else if (cfg_we_i) begin
      // R and Z belong to the reset block, unknown ids drop out
      case (cfg_id_i)
        // reu off or on
        ID_REU:         reu_cfg_o      <= cfg_val_i[0];
        // none, 25%, 50%, 75%
        ID_SCANLINES:   scanlines_o    <= cfg_val_i[1:0];
        // mute up to full volume
        ID_VOLUME:      volume_o       <= cfg_val_i[1:0];
        // 4:3 or 16:9
        ID_WIDE:        wide_screen_o  <= cfg_val_i[0];
        // one bit per drive
        ID_WPROT:       floppy_wprot_o <= cfg_val_i[1:0];
        // joystick port input devices
        ID_PORT1:       port_1_o       <= cfg_val_i[3:0];
        ID_PORT2:       port_2_o       <= cfg_val_i[3:0];
        ID_DOS:         dos_sel_o      <= cfg_val_i[1:0];
        ID_TURBO_MODE:  turbo_mode_o   <= cfg_val_i[1:0];
        ID_TURBO_SPEED: turbo_speed_o  <= cfg_val_i[1:0];
        // pause the core while the osd is open
        ID_PAUSE:       pause_o        <= cfg_val_i[0];
        // cartridge detach
        ID_DETACH:      detach_reset_o <= cfg_val_i[0];
        default: ;
      endcase
    end
  end

endmodule

//--- verilog/boot_reset_ctrl.sv
// power-on reset hold for the c64 core and the 1541 drive, released by timeout or the mcu
`timescale 1ns/1ps

module boot_reset_ctrl #(
  parameter int unsigned BOOT_HOLD = sysctrl_pkg::BOOT_HOLD_CYCLES
) (
  input  logic               clk,
  input  logic               main_reset_timeout,
  input  logic               cfg_we_i,
  input  sysctrl_pkg::byte_t cfg_id_i,
  input  sysctrl_pkg::byte_t cfg_val_i,
  output logic [1:0]         system_reset_o,
  output logic               drive_reset_o,
  output logic               hold_expired_o
);
  import sysctrl_pkg::*;

  // counts down to zero, zero means the hold is over or cancelled
  logic [31:0] boot_hold_cnt;

  // last cycle of the hold, high together with the release edge
  assign hold_expired_o = (boot_hold_cnt == 32'd1);

  always_ff @(posedge clk) begin
    if (main_reset_timeout) begin
      // cold boot until the mcu speaks or the hold runs out
      system_reset_o <= 2'd3;
      drive_reset_o  <= 1'b1;
      boot_hold_cnt  <= 32'(BOOT_HOLD);
    end else begin
      if (boot_hold_cnt != 32'd0) begin
        boot_hold_cnt <= boot_hold_cnt - 32'd1;
        if (hold_expired_o) begin
          system_reset_o <= 2'd0;
          drive_reset_o  <= 1'b0;
        end
      end
      if (cfg_we_i) begin
        // coldboot 3, reset 1 or run 0, and an active mcu cancels the hold
        if (cfg_id_i == ID_RESET) begin
          system_reset_o <= cfg_val_i[1:0];
          boot_hold_cnt  <= 32'd0;
        end
        if (cfg_id_i == ID_DRIVE_RESET) begin
          drive_reset_o <= cfg_val_i[0];
        end
      end
    end
  end

endmodule

//--- verilog/irq_ctrl.sv
// interrupt line toward the mcu, cold boot flag and acknowledge pulses
`timescale 1ns/1ps

module irq_ctrl (
  input  logic               clk,
  input  logic               main_reset_timeout,
  input  sysctrl_pkg::byte_t int_in_i,
  input  logic               irq_ack_we_i,
  input  sysctrl_pkg::byte_t irq_ack_val_i,
  input  logic               src_read_i,
  output logic               int_out_n_o,
  output sysctrl_pkg::byte_t int_ack_o,
  output logic               sys_int_o,
  output logic               coldboot_o
);
  import sysctrl_pkg::*;

  byte_t int_ack_q;

  assign int_ack_o = int_ack_q;

  // any core interrupt or the system interrupt pulls the line low
  assign int_out_n_o = !((int_in_i != 8'h00) || sys_int_o);

  always_ff @(posedge clk) begin
    if (main_reset_timeout) begin
      int_ack_q  <= '0;
      // power-on reset raises the cold boot interrupt
      sys_int_o  <= 1'b1;
      coldboot_o <= 1'b1;
    end else begin
      // ack lasts a single clk
      int_ack_q <= irq_ack_we_i ? irq_ack_val_i : 8'h00;
      // ack bit 0 retires the system interrupt
      if (int_ack_q[0]) begin
        sys_int_o <= 1'b0;
      end
      if (src_read_i) begin
        coldboot_o <= 1'b0;
      end
    end
  end

endmodule

//--- verilog/mcu_sysctrl_top.sv
// top of the system control block, connects the spi target, sequencer and control blocks
`timescale 1ns/1ps

module mcu_sysctrl_top #(
  parameter int unsigned BOOT_HOLD = sysctrl_pkg::BOOT_HOLD_CYCLES
) (
  input  logic                clk,
  input  logic                main_reset_timeout,
  input  logic                spi_csn_i,
  input  logic                spi_sck_i,
  input  logic                spi_mosi_i,
  output logic                spi_miso_o,
  input  logic [1:0]          buttons_i,
  input  sysctrl_pkg::byte_t  int_in_i,
  output logic [1:0]          leds_o,
  output sysctrl_pkg::color_t color_o,
  output logic                int_out_n_o,
  output sysctrl_pkg::byte_t  int_ack_o,
  output logic [1:0]          system_reset_o,
  output logic                drive_reset_o,
  output logic                cold_boot_o,
  output logic                reu_cfg_o,
  output logic [1:0]          scanlines_o,
  output logic [1:0]          volume_o,
  output logic                wide_screen_o,
  output logic [1:0]          floppy_wprot_o,
  output logic [3:0]          port_1_o,
  output logic [3:0]          port_2_o,
  output logic [1:0]          dos_sel_o,
  output logic [1:0]          turbo_mode_o,
  output logic [1:0]          turbo_speed_o,
  output logic                pause_o,
  output logic                detach_reset_o
);
  import sysctrl_pkg::*;

  // received byte stream
  logic  rx_strobe;
  logic  rx_start;
  byte_t rx_byte;
  byte_t tx_byte;
  // config write pulse, shared by cfg_store and the reset block
  logic  cfg_we;
  byte_t cfg_id;
  byte_t cfg_val;
  logic  irq_ack_we;
  byte_t irq_ack_val;
  logic  src_read;
  logic  sys_int;
  logic  hold_expired;

  mcu_spi_target u_mcu_spi_target (
    .clk                (clk),
    .main_reset_timeout (main_reset_timeout),
    .spi_csn_i          (spi_csn_i),
    .spi_sck_i          (spi_sck_i),
    .spi_mosi_i         (spi_mosi_i),
    .tx_byte_i          (tx_byte),
    .spi_miso_o         (spi_miso_o),
    .rx_strobe_o        (rx_strobe),
    .rx_start_o         (rx_start),
    .rx_byte_o          (rx_byte)
  );

  sysctrl u_sysctrl (
    .clk                (clk),
    .main_reset_timeout (main_reset_timeout),
    .rx_strobe_i        (rx_strobe),
    .rx_start_i         (rx_start),
    .rx_byte_i          (rx_byte),
    .buttons_i          (buttons_i),
    .int_in_i           (int_in_i),
    .sys_int_i          (sys_int),
    .coldboot_i         (cold_boot_o),
    .hold_expired_i     (hold_expired),
    .boot_color_i       (NO_MCU_COLOR),
    .tx_byte_o          (tx_byte),
    .leds_o             (leds_o),
    .color_o            (color_o),
    .cfg_we_o           (cfg_we),
    .cfg_id_o           (cfg_id),
    .cfg_val_o          (cfg_val),
    .irq_ack_we_o       (irq_ack_we),
    .irq_ack_val_o      (irq_ack_val),
    .src_read_o         (src_read)
  );

  cfg_store u_cfg_store (
    .clk                (clk),
    .main_reset_timeout (main_reset_timeout),
    .cfg_we_i           (cfg_we),
    .cfg_id_i           (cfg_id),
    .cfg_val_i          (cfg_val),
    .reu_cfg_o          (reu_cfg_o),
    .scanlines_o        (scanlines_o),
    .volume_o           (volume_o),
    .wide_screen_o      (wide_screen_o),
    .floppy_wprot_o     (floppy_wprot_o),
    .port_1_o           (port_1_o),
    .port_2_o           (port_2_o),
    .dos_sel_o          (dos_sel_o),
    .turbo_mode_o       (turbo_mode_o),
    .turbo_speed_o      (turbo_speed_o),
    .pause_o            (pause_o),
    .detach_reset_o     (detach_reset_o)
  );

  boot_reset_ctrl #(
    .BOOT_HOLD (BOOT_HOLD)
  ) u_boot_reset_ctrl (
    .clk                (clk),
    .main_reset_timeout (main_reset_timeout),
    .cfg_we_i           (cfg_we),
    .cfg_id_i           (cfg_id),
    .cfg_val_i          (cfg_val),
    .system_reset_o     (system_reset_o),
    .drive_reset_o      (drive_reset_o),
    .hold_expired_o     (hold_expired)
  );

  irq_ctrl u_irq_ctrl (
    .clk                (clk),
    .main_reset_timeout (main_reset_timeout),
    .int_in_i           (int_in_i),
    .irq_ack_we_i       (irq_ack_we),
    .irq_ack_val_i      (irq_ack_val),
    .src_read_i         (src_read),
    .int_out_n_o        (int_out_n_o),
    .int_ack_o          (int_ack_o),
    .sys_int_o          (sys_int),
    .coldboot_o         (cold_boot_o)
  );

endmodule

//--- sim/tb_mcu_sysctrl.sv
// testbench for the system control block, plays the board mcu over spi and checks a reference model
`timescale 1ns/1ps

module tb_mcu_sysctrl;
  import sysctrl_pkg::*;

  // short boot hold so the run stays small
  localparam int unsigned HOLD = 2000;
  // two holds plus about 200 spi bytes at 128 clk each, with margin
  localparam int TIMEOUT_CYCLES = 60_000;
  // sck half period in clk cycles, sck runs at clk/16
  localparam int SCK_HALF = 8;

  logic clk;
  logic main_reset_timeout;
  logic spi_csn, spi_sck, spi_mosi, spi_miso;
  logic [1:0] buttons;
  byte_t int_in;
  logic [1:0] leds;
  color_t color;
  logic int_out_n;
  byte_t int_ack;
  logic [1:0] system_reset;
  logic drive_reset, cold_boot;
  logic reu_cfg, wide_screen, pause, detach_reset;
  logic [1:0] scanlines, volume, floppy_wprot, dos_sel, turbo_mode, turbo_speed;
  logic [3:0] port_1, port_2;

  // reference model state
  logic [1:0] exp_leds;
  color_t exp_color;
  logic [1:0] exp_sysrst;
  logic exp_drvrst, exp_sys_int, exp_coldboot;
  logic exp_reu, exp_wide, exp_pause, exp_detach;
  logic [1:0] exp_scan, exp_vol, exp_wprot, exp_dos, exp_tmode, exp_tspeed;
  logic [3:0] exp_port1, exp_port2;

  // outputs move byte by byte inside a frame, the model catches up at its end
  logic link_busy;
  byte_t args_q[$];
  byte_t miso_q[$];
  // int_ack capture
  byte_t ack_last;
  int ack_count = 0;
  logic ack_prev = 1'b0;
  int cycle_cnt = 0;

  mcu_sysctrl_top #(
    .BOOT_HOLD (HOLD)
  ) u_mcu_sysctrl_top (
    .clk (clk), .main_reset_timeout (main_reset_timeout),
    .spi_csn_i (spi_csn), .spi_sck_i (spi_sck), .spi_mosi_i (spi_mosi),
    .spi_miso_o (spi_miso), .buttons_i (buttons), .int_in_i (int_in),
    .leds_o (leds), .color_o (color), .int_out_n_o (int_out_n), .int_ack_o (int_ack),
    .system_reset_o (system_reset), .drive_reset_o (drive_reset), .cold_boot_o (cold_boot),
    .reu_cfg_o (reu_cfg), .scanlines_o (scanlines), .volume_o (volume),
    .wide_screen_o (wide_screen), .floppy_wprot_o (floppy_wprot), .port_1_o (port_1),
    .port_2_o (port_2), .dos_sel_o (dos_sel), .turbo_mode_o (turbo_mode),
    .turbo_speed_o (turbo_speed), .pause_o (pause), .detach_reset_o (detach_reset)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  task automatic abort_run();
    $display("sim failed");
    $fatal(1, "stopping at the first error");
  endtask

  task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp) else begin
      $display("MISMATCH %s: got %h, expected %h", name, got, exp);
      abort_run();
    end
  endtask

  // color bytes travel lsb first
  function automatic byte_t reverse_bits(input byte_t b);
    return {b[0], b[1], b[2], b[3], b[4], b[5], b[6], b[7]};
  endfunction

  // wire order is g, b, r
  function automatic color_t color_from_bytes(input byte_t g, input byte_t b, input byte_t r);
    return {reverse_bits(r), reverse_bits(g), reverse_bits(b)};
  endfunction

  // bit 0 of the interrupt reply is the system interrupt
  function automatic byte_t irq_reply(input byte_t lines, input logic sys_int);
    return (lines & 8'hfe) | byte_t'(sys_int);
  endfunction

  // line idles high only with every source quiet
  function automatic logic int_line_n(input byte_t lines, input logic sys_int);
    return (lines == 8'h00) && !sys_int;
  endfunction

  // all fourteen ids, then a few the block does not know
  function automatic byte_t id_by_index(input int n);
    case (n)
      0:       return ID_REU;
      1:       return ID_RESET;
      2:       return ID_SCANLINES;
      3:       return ID_VOLUME;
      4:       return ID_WIDE;
      5:       return ID_WPROT;
      6:       return ID_PORT1;
      7:       return ID_PORT2;
      8:       return ID_DOS;
      9:       return ID_DRIVE_RESET;
      10:      return ID_TURBO_MODE;
      11:      return ID_TURBO_SPEED;
      12:      return ID_PAUSE;
      13:      return ID_DETACH;
      14:      return "B";
      15:      return "K";
      16:      return 8'h00;
      default: return 8'hff;
    endcase
  endfunction

  task automatic reset_model();
    exp_leds = 2'd0;
    exp_color = '0;
    // cold boot, drive held, system interrupt pending
    exp_sysrst = 2'd3;
    exp_drvrst = 1'b1;
    exp_sys_int = 1'b1;
    exp_coldboot = 1'b1;
    exp_reu = 1'b0;
    exp_scan = 2'd0;
    exp_vol = 2'd2;
    exp_wide = 1'b0;
    exp_wprot = 2'd0;
    exp_port1 = 4'd7;
    exp_port2 = 4'd0;
    exp_dos = 2'd0;
    exp_tmode = 2'd0;
    exp_tspeed = 2'd0;
    exp_pause = 1'b0;
    exp_detach = 1'b0;
  endtask

  // each setting keeps the low bits of the value that fit its width
  task automatic apply_cfg_write(input byte_t id, input byte_t val);
    case (id)
      ID_REU:         exp_reu = val[0];
      ID_RESET:       exp_sysrst = val[1:0];
      ID_SCANLINES:   exp_scan = val[1:0];
      ID_VOLUME:      exp_vol = val[1:0];
      ID_WIDE:        exp_wide = val[0];
      ID_WPROT:       exp_wprot = val[1:0];
      ID_PORT1:       exp_port1 = val[3:0];
      ID_PORT2:       exp_port2 = val[3:0];
      ID_DOS:         exp_dos = val[1:0];
      ID_DRIVE_RESET: exp_drvrst = val[0];
      ID_TURBO_MODE:  exp_tmode = val[1:0];
      ID_TURBO_SPEED: exp_tspeed = val[1:0];
      ID_PAUSE:       exp_pause = val[0];
      ID_DETACH:      exp_detach = val[0];
      default: ;
    endcase
  endtask

  task automatic apply_reset();
    main_reset_timeout = 1'b1;
    reset_model();
    repeat (10) @(negedge clk);
    main_reset_timeout = 1'b0;
  endtask

  // mode 0, mosi set while sck is low, miso taken just before sck rises
  task automatic spi_byte(input byte_t tx, output byte_t rx);
    byte_t shreg;
    shreg = tx;
    rx = 8'h00;
    repeat (8) begin
      spi_mosi = shreg[7];
      shreg = {shreg[6:0], 1'b0};
      repeat (SCK_HALF) @(negedge clk);
      rx = {rx[6:0], spi_miso};
      spi_sck = 1'b1;
      repeat (SCK_HALF) @(negedge clk);
      spi_sck = 1'b0;
    end
  endtask

  // miso_q[k] holds the byte seen while byte k went out, the answer to byte k-1
  task automatic run_frame(input byte_t cmd);
    byte_t rx;
    miso_q.delete();
    link_busy = 1'b1;
    spi_csn = 1'b0;
    repeat (SCK_HALF) @(negedge clk);
    spi_byte(cmd, rx);
    miso_q.push_back(rx);
    for (int k = 0; k < args_q.size(); k++) begin
      spi_byte(args_q[k], rx);
      miso_q.push_back(rx);
    end
    repeat (SCK_HALF) @(negedge clk);
    spi_csn = 1'b1;
    repeat (SCK_HALF) @(negedge clk);
  endtask

  task automatic read_status();
    args_q.delete();
    repeat (4) args_q.push_back(byte_t'($urandom));
    run_frame(CMD_STATUS);
    check_eq("spi_miso_o status byte 0", 32'(miso_q[2]), 32'(STATUS_MAGIC0));
    check_eq("spi_miso_o status byte 1", 32'(miso_q[3]), 32'(STATUS_MAGIC1));
    check_eq("spi_miso_o core id", 32'(miso_q[4]), 32'(CORE_ID));
    link_busy = 1'b0;
  endtask

  task automatic read_buttons();
    args_q.delete();
    args_q.push_back(8'h00);
    args_q.push_back(8'h00);
    run_frame(CMD_BUTTONS);
    check_eq("spi_miso_o buttons", 32'(miso_q[2]), 32'(buttons));
    link_busy = 1'b0;
  endtask

  task automatic write_leds(input byte_t val);
    args_q.delete();
    args_q.push_back(val);
    run_frame(CMD_LEDS);
    exp_leds = val[1:0];
    link_busy = 1'b0;
  endtask

  task automatic write_color(input byte_t g, input byte_t b, input byte_t r);
    args_q.delete();
    args_q.push_back(g);
    args_q.push_back(b);
    args_q.push_back(r);
    run_frame(CMD_COLOR);
    exp_color = color_from_bytes(g, b, r);
    link_busy = 1'b0;
  endtask

  task automatic write_config(input byte_t id, input byte_t val);
    args_q.delete();
    args_q.push_back(id);
    args_q.push_back(val);
    run_frame(CMD_CONFIG);
    apply_cfg_write(id, val);
    link_busy = 1'b0;
  endtask

  // reply reflects sys_int before this acknowledge takes effect
  task automatic ack_irq(input byte_t ack);
    int count_before;
    logic sys_before;
    count_before = ack_count;
    sys_before = exp_sys_int;
    args_q.delete();
    args_q.push_back(ack);
    args_q.push_back(8'h00);
    run_frame(CMD_IRQ);
    check_eq("spi_miso_o irq", 32'(miso_q[2]), 32'(irq_reply(int_in, sys_before)));
    if (ack != 8'h00) begin
      check_eq("int_ack_o pulse count", 32'(ack_count), 32'(count_before + 1));
      check_eq("int_ack_o", 32'(ack_last), 32'(ack));
    end else begin
      check_eq("int_ack_o pulse count", 32'(ack_count), 32'(count_before));
    end
    if (ack[0]) begin
      exp_sys_int = 1'b0;
    end
    link_busy = 1'b0;
  endtask

  task automatic read_irq_source();
    args_q.delete();
    args_q.push_back(8'h00);
    args_q.push_back(8'h00);
    run_frame(CMD_IRQ_SRC);
    check_eq("spi_miso_o coldboot", 32'(miso_q[2]), 32'(exp_coldboot));
    exp_coldboot = 1'b0;
    link_busy = 1'b0;
  endtask

  task automatic compare_outputs();
    check_eq("leds_o", 32'(leds), 32'(exp_leds));
    check_eq("color_o", 32'(color), 32'(exp_color));
    check_eq("system_reset_o", 32'(system_reset), 32'(exp_sysrst));
    check_eq("drive_reset_o", 32'(drive_reset), 32'(exp_drvrst));
    check_eq("cold_boot_o", 32'(cold_boot), 32'(exp_coldboot));
    check_eq("int_out_n_o", 32'(int_out_n), 32'(int_line_n(int_in, exp_sys_int)));
    check_eq("reu_cfg_o", 32'(reu_cfg), 32'(exp_reu));
    check_eq("scanlines_o", 32'(scanlines), 32'(exp_scan));
    check_eq("volume_o", 32'(volume), 32'(exp_vol));
    check_eq("wide_screen_o", 32'(wide_screen), 32'(exp_wide));
    check_eq("floppy_wprot_o", 32'(floppy_wprot), 32'(exp_wprot));
    check_eq("port_1_o", 32'(port_1), 32'(exp_port1));
    check_eq("port_2_o", 32'(port_2), 32'(exp_port2));
    check_eq("dos_sel_o", 32'(dos_sel), 32'(exp_dos));
    check_eq("turbo_mode_o", 32'(turbo_mode), 32'(exp_tmode));
    check_eq("turbo_speed_o", 32'(turbo_speed), 32'(exp_tspeed));
    check_eq("pause_o", 32'(pause), 32'(exp_pause));
    check_eq("detach_reset_o", 32'(detach_reset), 32'(exp_detach));
  endtask

  // values read at the edge are the ones settled during the last cycle
  always @(posedge clk) begin
    if (!main_reset_timeout && !link_busy) begin
      compare_outputs();
    end
  end

  // int_ack must drop again after one clk
  always @(posedge clk) begin
    if (int_ack != 8'h00) begin
      assert (!ack_prev) else begin
        $display("int_ack stayed non-zero for more than one clock cycle");
        abort_run();
      end
      ack_last = int_ack;
      ack_count++;
    end
    ack_prev = (int_ack != 8'h00);
  end

  always @(posedge clk) begin
    cycle_cnt++;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("timeout: the run did not finish within %0d clock cycles", TIMEOUT_CYCLES);
      abort_run();
    end
  end

  initial begin
    byte_t v;
    void'($urandom(32'hb084));
    spi_csn = 1'b1;
    spi_sck = 1'b0;
    spi_mosi = 1'b0;
    buttons = 2'b00;
    int_in = 8'h00;
    link_busy = 1'b0;
    apply_reset();

    // defaults hold with no traffic, resets drop on the hold's last edge
    repeat (HOLD) @(negedge clk);
    exp_sysrst = 2'd0;
    exp_drvrst = 1'b0;
    exp_color = NO_MCU_COLOR;
    repeat (4) @(negedge clk);
    check_eq("color_o", 32'(color), 32'(NO_MCU_COLOR));

    // status signature and buttons
    read_status();
    repeat (3) begin
      buttons = 2'($urandom);
      read_buttons();
    end

    // leds and color
    repeat (4) begin
      write_leds(byte_t'($urandom));
      write_color(byte_t'($urandom), byte_t'($urandom), byte_t'($urandom));
    end

    // every id once, bit 0 set so each setting moves off its default
    for (int n = 0; n < 18; n++) begin
      write_config(id_by_index(n), byte_t'($urandom) | 8'h01);
    end
    // then random ids and values
    repeat (12) begin
      write_config(id_by_index($urandom % 18), byte_t'($urandom));
    end

    // early R write cancels the hold
    apply_reset();
    repeat (20) @(negedge clk);
    v = byte_t'($urandom) | 8'h01;
    write_config(ID_RESET, v);
    repeat (HOLD + 100) @(negedge clk);
    check_eq("system_reset_o", 32'(system_reset), 32'(v[1:0]));
    check_eq("color_o", 32'(color), 32'h0);
    write_config(ID_DRIVE_RESET, 8'h00);
    check_eq("drive_reset_o", 32'(drive_reset), 32'h0);
    write_config(ID_DRIVE_RESET, 8'h01);
    check_eq("drive_reset_o", 32'(drive_reset), 32'h1);

    // interrupts, first ack keeps sys_int, second retires it
    int_in = byte_t'($urandom) | 8'h10;
    ack_irq((byte_t'($urandom) & 8'hfe) | 8'h02);
    ack_irq(byte_t'($urandom) | 8'h01);
    int_in = 8'h00;
    repeat (4) @(negedge clk);
    check_eq("int_out_n_o", 32'(int_out_n), 32'h1);
    int_in = byte_t'($urandom) | 8'h01;
    repeat (4) @(negedge clk);
    check_eq("int_out_n_o", 32'(int_out_n), 32'h0);
    ack_irq(8'h00);
    read_irq_source();
    read_irq_source();
    check_eq("cold_boot_o", 32'(cold_boot), 32'h0);

    $display("sim passed");
    $finish;
  end

endmodule

//--- mcu_sysctrl.f
verilog/sysctrl_pkg.sv
verilog/mcu_spi_target.sv
verilog/sysctrl.sv
verilog/cfg_store.sv
verilog/boot_reset_ctrl.sv
verilog/irq_ctrl.sv
verilog/mcu_sysctrl_top.sv
sim/tb_mcu_sysctrl.sv

//--- Makefile
# Verilator build and run for the MCU system control block

TOP := tb_mcu_sysctrl

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): mcu_sysctrl.f $(wildcard verilog/*.sv) $(wildcard sim/*.sv)
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f mcu_sysctrl.f

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "^sim passed$$" sim.log

lint:
	verilator --lint-only --timing --top-module mcu_sysctrl_top -f mcu_sysctrl.f

clean:
	rm -rf obj_dir sim.log
